// ==== verilog/arm_state_defines.svh ====
`ifndef ARM_STATE_DEFINES_SVH
`define ARM_STATE_DEFINES_SVH

// Request FIFO depth.
`define ARM_FIFO_DEPTH          4

// Physical register map.
`define ARM_PHY_REGS            37
`define ARM_PHY_PC              6'd15
`define ARM_PHY_FIQ_R8          6'd16
`define ARM_PHY_FIQ_R13         6'd21
`define ARM_PHY_IRQ_R13         6'd23
`define ARM_PHY_SVC_R13         6'd25
`define ARM_PHY_ABT_R13         6'd27
`define ARM_PHY_UND_R13         6'd29
`define ARM_PHY_CPSR            6'd31
`define ARM_PHY_SPSR_FIQ        6'd32
`define ARM_PHY_SPSR_IRQ        6'd33
`define ARM_PHY_SPSR_SVC        6'd34
`define ARM_PHY_SPSR_ABT        6'd35
`define ARM_PHY_SPSR_UND        6'd36

// Bus word addresses above the r0 to r15 window.
`define ARM_ADDR_CPSR           5'h10
`define ARM_ADDR_RAISE          5'h11
`define ARM_ADDR_RETURN         5'h12
`define ARM_ADDR_SPSR           5'h13

// Exception vectors.
`define ARM_VEC_UND             32'h0000_0004
`define ARM_VEC_SWI             32'h0000_0008
`define ARM_VEC_IABT            32'h0000_000C
`define ARM_VEC_DABT            32'h0000_0010
`define ARM_VEC_IRQ             32'h0000_0018
`define ARM_VEC_FIQ             32'h0000_001C

`endif

// ==== verilog/arm_state_pkg.sv ====
package arm_state_pkg;

        // Processor mode encodings as held in CPSR[4:0].
        typedef enum logic [4:0] {
                USR = 5'b10000,
                FIQ = 5'b10001,
                IRQ = 5'b10010,
                SVC = 5'b10011,
                ABT = 5'b10111,
                UND = 5'b11011
        } cpu_mode_e;

        typedef enum logic [1:0] {
                OP_WRITE_REG,
                OP_WRITE_CPSR,
                OP_RAISE,
                OP_RETURN
        } req_op_e;

        // Exception kinds, carried in the low bits of a raise request.
        typedef enum logic [2:0] {
                EXC_DABT,
                EXC_FIQ,
                EXC_IRQ,
                EXC_IABT,
                EXC_SWI,
                EXC_UND
        } exc_kind_e;

        typedef struct packed {
                req_op_e     op;
                logic [3:0]  arch_index;
                logic [31:0] data;
        } state_req_t;

        typedef struct packed {
                logic        n;
                logic        z;
                logic        c;
                logic        v;
                logic [19:0] reserved;
                logic        i;
                logic        f;
                logic        t;
                cpu_mode_e   mode;
        } psr_fields_t;

        // Status word as a raw bus value or as decoded fields.
        typedef union packed {
                logic [31:0] raw;
                psr_fields_t fields;
        } psr_word_u;

endpackage

// ==== verilog/wb_state_slave.sv ====
`timescale 1ns/1ps
`include "arm_state_defines.svh"

module wb_state_slave (
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_wb_cyc,
        input  logic                      i_wb_stb,
        input  logic                      i_wb_we,
        input  logic [4:0]                i_wb_adr,
        input  logic [31:0]               i_wb_dat,
        input  logic                      i_fifo_full,
        input  logic                      i_fifo_empty,
        input  logic [31:0]               i_rd_data,
        output logic                      o_wb_ack,
        output logic [31:0]               o_wb_dat,
        output logic                      o_push,
        output arm_state_pkg::state_req_t o_req,
        output logic [3:0]                o_rd_arch_index,
        output logic                      o_rd_sel_cpsr,
        output logic                      o_rd_sel_spsr
);
        import arm_state_pkg::*;

        logic bus_req;
        logic wr_cmd;
        logic wr_go;
        logic rd_go;
        logic rd_known;

        // An access is new until its ack has been sent.
        assign bus_req = i_wb_cyc && i_wb_stb && !o_wb_ack;

        always_comb
        begin
                o_req.op         = OP_WRITE_REG;
                o_req.arch_index = i_wb_adr[3:0];
                o_req.data       = i_wb_dat;
                wr_cmd           = 1'b1;
                if (i_wb_adr[4])
                begin
                        case (i_wb_adr)
                                `ARM_ADDR_CPSR:   o_req.op = OP_WRITE_CPSR;
                                `ARM_ADDR_RAISE:  o_req.op = OP_RAISE;
                                `ARM_ADDR_RETURN: o_req.op = OP_RETURN;
                                default:          wr_cmd   = 1'b0;
                        endcase
                end
        end

        assign o_rd_arch_index = i_wb_adr[3:0];
        assign o_rd_sel_cpsr   = (i_wb_adr == `ARM_ADDR_CPSR);
        assign o_rd_sel_spsr   = (i_wb_adr == `ARM_ADDR_SPSR);
        assign rd_known        = !i_wb_adr[4] || o_rd_sel_cpsr || o_rd_sel_spsr;

        // Writes to unused addresses finish without a request.
        assign wr_go  = bus_req && i_wb_we && (!i_fifo_full || !wr_cmd);
        assign o_push = wr_go && wr_cmd;

        // A read is held until all earlier writes have been applied.
        assign rd_go = bus_req && !i_wb_we && i_fifo_empty;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_wb_ack <= 1'b0;
                else
                        o_wb_ack <= wr_go || rd_go;
        end

        always_ff @(posedge i_clk)
        begin
                if (rd_go)
                        o_wb_dat <= rd_known ? i_rd_data : 32'd0;
        end

        a_ack_with_stb: assert property (@(posedge i_clk) disable iff (i_reset)
                o_wb_ack |-> i_wb_stb);

endmodule

// ==== verilog/state_req_fifo.sv ====
`timescale 1ns/1ps
`include "arm_state_defines.svh"

module state_req_fifo (
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_push,
        input  arm_state_pkg::state_req_t i_req,
        input  logic                      i_pop,
        output logic                      o_full,
        output logic                      o_empty,
        output logic                      o_valid,
        output arm_state_pkg::state_req_t o_head
);
        import arm_state_pkg::*;

        localparam int DEPTH = `ARM_FIFO_DEPTH;
        localparam int PTR_W = $clog2(DEPTH);
        localparam int CNT_W = $clog2(DEPTH + 1);

        state_req_t       mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
                return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        endfunction

        assign o_full  = (count == CNT_W'(DEPTH));
        assign o_empty = (count == '0);
        assign o_valid = !o_empty;
        assign o_head  = mem[rd_ptr];

        always_ff @(posedge i_clk)
        begin
                if (i_push)
                        mem[wr_ptr] <= i_req;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (i_push)
                                wr_ptr <= ptr_inc(wr_ptr);
                        if (i_pop)
                                rd_ptr <= ptr_inc(rd_ptr);
                        // Push and pop together leave the count as it is.
                        case ({i_push, i_pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
                i_push |-> !o_full);

        a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
                i_pop |-> !o_empty);

endmodule

// ==== verilog/bank_index_map.sv ====
`timescale 1ns/1ps
`include "arm_state_defines.svh"

module bank_index_map (
        input  logic [3:0]               i_arch_index,
        input  arm_state_pkg::cpu_mode_e i_mode,
        output logic [5:0]               o_phy_index
);
        import arm_state_pkg::*;

        logic       is_sp_lr;
        logic [5:0] bank_base;

        assign is_sp_lr = (i_arch_index == 4'd13) || (i_arch_index == 4'd14);

        // Location of r13 in each privileged bank.
        always_comb
        begin
                case (i_mode)
                        IRQ:     bank_base = `ARM_PHY_IRQ_R13;
                        SVC:     bank_base = `ARM_PHY_SVC_R13;
                        ABT:     bank_base = `ARM_PHY_ABT_R13;
                        UND:     bank_base = `ARM_PHY_UND_R13;
                        default: bank_base = 6'd0;
                endcase
        end

        always_comb
        begin
                o_phy_index = {2'b00, i_arch_index};
                if (i_mode == FIQ)
                begin
                        // FIQ r8 to r14 sit in one contiguous block.
                        if (i_arch_index >= 4'd8 && i_arch_index != 4'd15)
                                o_phy_index = `ARM_PHY_FIQ_R8 + 6'(i_arch_index - 4'd8);
                end
                else if (i_mode != USR && is_sp_lr)
                begin
                        o_phy_index = bank_base + 6'(i_arch_index - 4'd13);
                end
        end

endmodule

// ==== verilog/banked_register_file.sv ====
`timescale 1ns/1ps
`include "arm_state_defines.svh"

module banked_register_file (
        input  logic                      i_clk,
        input  logic                      i_reset,
        input  logic                      i_valid,
        input  arm_state_pkg::state_req_t i_req,
        input  logic [5:0]                i_wr_phy,
        input  logic [5:0]                i_rd_phy,
        input  logic                      i_rd_sel_cpsr,
        input  logic                      i_rd_sel_spsr,
        output logic                      o_pop,
        output logic [31:0]               o_rd_data,
        output arm_state_pkg::cpu_mode_e  o_mode,
        output logic [31:0]               o_pc,
        output logic [31:0]               o_cpsr,
        output logic                      o_flush
);
        import arm_state_pkg::*;

        localparam int          NREGS      = `ARM_PHY_REGS;
        // SVC mode with IRQ and FIQ masked.
        localparam logic [31:0] RESET_CPSR = {24'd0, 3'b110, SVC};

        logic [31:0] regs     [NREGS];
        logic [31:0] regs_nxt [NREGS];
        psr_word_u   cpsr;
        psr_word_u   cpsr_nxt;
        logic        flush_nxt;
        exc_kind_e   kind;
        cpu_mode_e   exc_mode;
        logic [31:0] exc_vec;
        logic        exc_ok;

        function automatic logic legal_mode(input logic [4:0] m);
                return m inside {USR, FIQ, IRQ, SVC, ABT, UND};
        endfunction

        function automatic logic [5:0] spsr_phy(input cpu_mode_e m);
                case (m)
                        FIQ:     return `ARM_PHY_SPSR_FIQ;
                        IRQ:     return `ARM_PHY_SPSR_IRQ;
                        ABT:     return `ARM_PHY_SPSR_ABT;
                        UND:     return `ARM_PHY_SPSR_UND;
                        default: return `ARM_PHY_SPSR_SVC;
                endcase
        endfunction

        function automatic logic [5:0] lr_phy(input cpu_mode_e m);
                case (m)
                        FIQ:     return `ARM_PHY_FIQ_R13 + 6'd1;
                        IRQ:     return `ARM_PHY_IRQ_R13 + 6'd1;
                        ABT:     return `ARM_PHY_ABT_R13 + 6'd1;
                        UND:     return `ARM_PHY_UND_R13 + 6'd1;
                        default: return `ARM_PHY_SVC_R13 + 6'd1;
                endcase
        endfunction

        assign cpsr.raw = regs[`ARM_PHY_CPSR];
        assign o_cpsr   = cpsr.raw;
        assign o_mode   = cpsr.fields.mode;
        assign o_pc     = regs[`ARM_PHY_PC];
        assign o_pop    = i_valid;

        // Target mode and vector of a raise; masked interrupts are dropped.
        always_comb
        begin
                kind     = exc_kind_e'(i_req.data[2:0]);
                exc_ok   = 1'b1;
                exc_mode = ABT;
                exc_vec  = `ARM_VEC_DABT;
                case (kind)
                        EXC_DABT: exc_vec = `ARM_VEC_DABT;
                        EXC_IABT: exc_vec = `ARM_VEC_IABT;
                        EXC_FIQ:
                        begin
                                exc_mode = FIQ;
                                exc_vec  = `ARM_VEC_FIQ;
                                exc_ok   = !cpsr.fields.f;
                        end
                        EXC_IRQ:
                        begin
                                exc_mode = IRQ;
                                exc_vec  = `ARM_VEC_IRQ;
                                exc_ok   = !cpsr.fields.i;
                        end
                        EXC_SWI:
                        begin
                                exc_mode = SVC;
                                exc_vec  = `ARM_VEC_SWI;
                        end
                        EXC_UND:
                        begin
                                exc_mode = UND;
                                exc_vec  = `ARM_VEC_UND;
                        end
                        default: exc_ok = 1'b0;
                endcase
        end

        always_comb
        begin
                regs_nxt  = regs;
                cpsr_nxt  = cpsr;
                flush_nxt = 1'b0;
                if (i_valid)
                begin
                        case (i_req.op)
                                OP_WRITE_REG:
                                begin
                                        regs_nxt[i_wr_phy] = i_req.data;
                                        flush_nxt          = (i_req.arch_index == 4'd15);
                                end
                                OP_WRITE_CPSR:
                                begin
                                        // User code may only touch the condition flags.
                                        if (cpsr.fields.mode == USR)
                                                cpsr_nxt.raw[31:28] = i_req.data[31:28];
                                        else
                                                cpsr_nxt.raw = i_req.data;
                                end
                                OP_RAISE:
                                begin
                                        if (exc_ok)
                                        begin
                                                regs_nxt[spsr_phy(exc_mode)] = cpsr.raw;
                                                regs_nxt[lr_phy(exc_mode)]   = o_pc + 32'd4;
                                                regs_nxt[`ARM_PHY_PC]        = exc_vec;
                                                cpsr_nxt.fields.mode         = exc_mode;
                                                cpsr_nxt.fields.i            = 1'b1;
                                                if (exc_mode == FIQ)
                                                        cpsr_nxt.fields.f = 1'b1;
                                                flush_nxt = 1'b1;
                                        end
                                end
                                default:
                                begin
                                        if (cpsr.fields.mode != USR)
                                        begin
                                                cpsr_nxt.raw = regs[spsr_phy(cpsr.fields.mode)];
                                                regs_nxt[`ARM_PHY_PC] = i_req.data;
                                                flush_nxt             = 1'b1;
                                        end
                                end
                        endcase
                        if (i_req.op == OP_WRITE_CPSR && cpsr_nxt.raw[7:0] != cpsr.raw[7:0])
                                flush_nxt = 1'b1;
                end
                regs_nxt[`ARM_PHY_CPSR] = cpsr_nxt.raw;
        end

        always_comb
        begin
                if (i_rd_sel_cpsr)
                        o_rd_data = cpsr.raw;
                else if (i_rd_sel_spsr && cpsr.fields.mode == USR)
                        o_rd_data = 32'd0;
                else if (i_rd_sel_spsr)
                        o_rd_data = regs[spsr_phy(cpsr.fields.mode)];
                else
                        o_rd_data = regs[i_rd_phy];
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int k = 0; k < NREGS; k++)
                                regs[k] <= 32'd0;
                        regs[`ARM_PHY_CPSR] <= RESET_CPSR;
                        o_flush             <= 1'b0;
                end
                else
                begin
                        regs    <= regs_nxt;
                        o_flush <= flush_nxt;
                end
        end

        // Bus data never leaves the CPSR in a mode the banking cannot map.
        a_mode_legal: assert property (@(posedge i_clk) disable iff (i_reset)
                legal_mode(cpsr.raw[4:0]));

endmodule

// ==== verilog/arm_state_top.sv ====
`timescale 1ns/1ps

module arm_state_top (
        input  logic        i_clk,
        input  logic        i_reset,
        input  logic        i_wb_cyc,
        input  logic        i_wb_stb,
        input  logic        i_wb_we,
        input  logic [4:0]  i_wb_adr,
        input  logic [31:0] i_wb_dat,
        output logic        o_wb_ack,
        output logic [31:0] o_wb_dat,
        output logic [31:0] o_pc,
        output logic [31:0] o_cpsr,
        output logic        o_flush
);
        import arm_state_pkg::*;

        state_req_t  push_req;
        state_req_t  head_req;
        logic        push;
        logic        pop;
        logic        fifo_full;
        logic        fifo_empty;
        logic        fifo_valid;
        logic [3:0]  rd_arch_index;
        logic        rd_sel_cpsr;
        logic        rd_sel_spsr;
        logic [31:0] rd_data;
        logic [5:0]  rd_phy;
        logic [5:0]  wr_phy;
        cpu_mode_e   mode;

        wb_state_slave u_slave (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_wb_cyc        (i_wb_cyc),
                .i_wb_stb        (i_wb_stb),
                .i_wb_we         (i_wb_we),
                .i_wb_adr        (i_wb_adr),
                .i_wb_dat        (i_wb_dat),
                .i_fifo_full     (fifo_full),
                .i_fifo_empty    (fifo_empty),
                .i_rd_data       (rd_data),
                .o_wb_ack        (o_wb_ack),
                .o_wb_dat        (o_wb_dat),
                .o_push          (push),
                .o_req           (push_req),
                .o_rd_arch_index (rd_arch_index),
                .o_rd_sel_cpsr   (rd_sel_cpsr),
                .o_rd_sel_spsr   (rd_sel_spsr)
        );

        state_req_fifo u_fifo (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_push  (push),
                .i_req   (push_req),
                .i_pop   (pop),
                .o_full  (fifo_full),
                .o_empty (fifo_empty),
                .o_valid (fifo_valid),
                .o_head  (head_req)
        );

        // Both maps follow the mode the register file holds now.
        bank_index_map u_rd_map (
                .i_arch_index (rd_arch_index),
                .i_mode       (mode),
                .o_phy_index  (rd_phy)
        );

        bank_index_map u_wr_map (
                .i_arch_index (head_req.arch_index),
                .i_mode       (mode),
                .o_phy_index  (wr_phy)
        );

        banked_register_file u_regs (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_valid       (fifo_valid),
                .i_req         (head_req),
                .i_wr_phy      (wr_phy),
                .i_rd_phy      (rd_phy),
                .i_rd_sel_cpsr (rd_sel_cpsr),
                .i_rd_sel_spsr (rd_sel_spsr),
                .o_pop         (pop),
                .o_rd_data     (rd_data),
                .o_mode        (mode),
                .o_pc          (o_pc),
                .o_cpsr        (o_cpsr),
                .o_flush       (o_flush)
        );

endmodule

// ==== verif/tb_arm_state_top.sv ====
`timescale 1ns/1ps
`include "arm_state_defines.svh"

module tb_arm_state_top;
        import arm_state_pkg::*;

        localparam int          CYCLES_PER_STEP = 40;
        localparam int          ACK_LIMIT       = 32;
        localparam logic [31:0] SEED            = 32'h217d2886;

        // Expected status words, built from the mode codes and the i/f bits.
        localparam logic [31:0] PSR_SVC_IF      = 32'h0000_00D3;
        localparam logic [31:0] PSR_FIQ_IF      = 32'h0000_00D1;
        localparam logic [31:0] PSR_SVC_ZC_F    = 32'h6000_0053;
        localparam logic [31:0] PSR_IRQ_ZC_IF   = 32'h6000_00D2;
        localparam logic [31:0] PSR_USR         = 32'h0000_0010;
        localparam logic [31:0] PSR_ALL_FLAGS   = 32'hF000_00D3;
        localparam logic [31:0] PSR_USR_FLAGS   = 32'hF000_0010;

        typedef struct packed {
                logic        is_read;
                logic        burst;
                logic [4:0]  adr;
                logic [31:0] data;
                logic [31:0] exp;
                logic [31:0] exp_pc;
        } entry_t;

        logic        i_clk;
        logic        i_reset;
        logic        i_wb_cyc;
        logic        i_wb_stb;
        logic        i_wb_we;
        logic [4:0]  i_wb_adr;
        logic [31:0] i_wb_dat;
        logic        o_wb_ack;
        logic [31:0] o_wb_dat;
        logic [31:0] o_pc;
        logic [31:0] o_cpsr;
        logic        o_flush;

        entry_t      steps [$];
        string       names [$];
        logic        steps_ready;
        int          checks;
        int          mismatches;
        int          timeouts;
        logic [31:0] seed_ret;

        arm_state_top DUT (
                .i_clk    (i_clk),
                .i_reset  (i_reset),
                .i_wb_cyc (i_wb_cyc),
                .i_wb_stb (i_wb_stb),
                .i_wb_we  (i_wb_we),
                .i_wb_adr (i_wb_adr),
                .i_wb_dat (i_wb_dat),
                .o_wb_ack (o_wb_ack),
                .o_wb_dat (o_wb_dat),
                .o_pc     (o_pc),
                .o_cpsr   (o_cpsr),
                .o_flush  (o_flush)
        );

        // 8 ns period.
        always #4 i_clk = ~i_clk;

        function automatic void add_write(input string name, input logic [4:0] adr,
                                          input logic [31:0] data, input logic burst);
                entry_t e;
                e = '{is_read: 1'b0, burst: burst, adr: adr, data: data,
                      exp: 32'd0, exp_pc: 32'd0};
                steps.push_back(e);
                names.push_back(name);
        endfunction

        function automatic void add_read(input string name, input logic [4:0] adr,
                                         input logic [31:0] exp, input logic [31:0] exp_pc);
                entry_t e;
                e = '{is_read: 1'b1, burst: 1'b0, adr: adr, data: 32'd0,
                      exp: exp, exp_pc: exp_pc};
                steps.push_back(e);
                names.push_back(name);
        endfunction

        task automatic build_steps();
                logic [31:0] burst_val [8];
                // Register writes and readback in SVC mode.
                add_write("svc_wr_r1", 5'd1, 32'h1111_0001, 1'b0);
                add_write("svc_wr_r13", 5'd13, 32'h5C5C_0013, 1'b0);
                add_write("svc_wr_r14", 5'd14, 32'h5C5C_0014, 1'b0);
                add_write("usr_wr_r8", 5'd8, 32'h0808_0808, 1'b0);
                add_read("svc_rd_r1", 5'd1, 32'h1111_0001, 32'd0);
                add_read("svc_rd_r13", 5'd13, 32'h5C5C_0013, 32'd0);
                add_read("svc_rd_r14", 5'd14, 32'h5C5C_0014, 32'd0);
                // FIQ bank against the user and SVC registers.
                add_write("to_fiq", `ARM_ADDR_CPSR, PSR_FIQ_IF, 1'b0);
                add_write("fiq_wr_r8", 5'd8, 32'hF1F1_0008, 1'b0);
                add_write("fiq_wr_r13", 5'd13, 32'hF1F1_000D, 1'b0);
                add_read("fiq_rd_r8", 5'd8, 32'hF1F1_0008, 32'd0);
                add_write("to_svc", `ARM_ADDR_CPSR, PSR_SVC_IF, 1'b0);
                add_read("svc_rd_user_r8", 5'd8, 32'h0808_0808, 32'd0);
                add_read("svc_rd_own_r13", 5'd13, 32'h5C5C_0013, 32'd0);
                add_write("back_to_fiq", `ARM_ADDR_CPSR, PSR_FIQ_IF, 1'b0);
                add_read("fiq_rd_r8_again", 5'd8, 32'hF1F1_0008, 32'd0);
                add_read("fiq_rd_r13_again", 5'd13, 32'hF1F1_000D, 32'd0);
                add_read("fiq_rd_cpsr", `ARM_ADDR_CPSR, PSR_FIQ_IF, 32'd0);
                // IRQ entry from SVC with i cleared; PC + 4 lands in the IRQ r14.
                add_write("svc_clear_i", `ARM_ADDR_CPSR, PSR_SVC_ZC_F, 1'b0);
                add_write("set_pc", 5'd15, 32'h0000_1000, 1'b0);
                add_read("rd_pc", 5'd15, 32'h0000_1000, 32'h0000_1000);
                add_write("raise_irq", `ARM_ADDR_RAISE, {29'd0, EXC_IRQ}, 1'b0);
                add_read("irq_rd_cpsr", `ARM_ADDR_CPSR, PSR_IRQ_ZC_IF, `ARM_VEC_IRQ);
                add_read("irq_rd_r14", 5'd14, 32'h0000_1004, `ARM_VEC_IRQ);
                add_read("irq_rd_spsr", `ARM_ADDR_SPSR, PSR_SVC_ZC_F, `ARM_VEC_IRQ);
                add_write("raise_irq_masked", `ARM_ADDR_RAISE, {29'd0, EXC_IRQ}, 1'b0);
                add_read("masked_rd_pc", 5'd15, `ARM_VEC_IRQ, `ARM_VEC_IRQ);
                // Return restores the SVC status word.
                add_write("irq_return", `ARM_ADDR_RETURN, 32'h0000_2000, 1'b0);
                add_read("ret_rd_cpsr", `ARM_ADDR_CPSR, PSR_SVC_ZC_F, 32'h0000_2000);
                add_read("ret_rd_svc_r14", 5'd14, 32'h5C5C_0014, 32'h0000_2000);
                // User mode may change only the flags and cannot return.
                add_write("to_usr", `ARM_ADDR_CPSR, PSR_USR, 1'b0);
                add_read("usr_rd_cpsr", `ARM_ADDR_CPSR, PSR_USR, 32'h0000_2000);
                add_write("usr_wr_cpsr", `ARM_ADDR_CPSR, PSR_ALL_FLAGS, 1'b0);
                add_read("usr_rd_flags", `ARM_ADDR_CPSR, PSR_USR_FLAGS, 32'h0000_2000);
                add_write("usr_return", `ARM_ADDR_RETURN, 32'h0000_3000, 1'b0);
                add_read("usr_rd_after_ret", `ARM_ADDR_CPSR, PSR_USR_FLAGS, 32'h0000_2000);
                add_read("usr_rd_r13", 5'd13, 32'd0, 32'h0000_2000);
                add_read("usr_rd_spsr", `ARM_ADDR_SPSR, 32'd0, 32'h0000_2000);
                // Eight writes over r0 to r3, so each register is written twice.
                for (int k = 0; k < 8; k++)
                begin
                        burst_val[k] = $urandom();
                        add_write($sformatf("burst_wr_%0d", k), 5'(k % 4), burst_val[k], 1'b1);
                end
                for (int k = 0; k < 4; k++)
                        add_read($sformatf("burst_rd_r%0d", k), 5'(k), burst_val[k + 4],
                                 32'h0000_2000);
        endtask

        task automatic wait_ack(input string name);
                int cycles;
                cycles = 0;
                do
                begin
                        @(negedge i_clk);
                        cycles++;
                end
                while (!o_wb_ack && cycles < ACK_LIMIT);
                if (!o_wb_ack)
                begin
                        $display("No bus ack for %s within %0d cycles", name, ACK_LIMIT);
                        timeouts++;
                end
        endtask

        task automatic bus_write(input string name, input logic [4:0] adr,
                                 input logic [31:0] data);
                i_wb_cyc = 1'b1;
                i_wb_stb = 1'b1;
                i_wb_we  = 1'b1;
                i_wb_adr = adr;
                i_wb_dat = data;
                wait_ack(name);
        endtask

        task automatic bus_read(input string name, input logic [4:0] adr,
                                output logic [31:0] data);
                i_wb_cyc = 1'b1;
                i_wb_stb = 1'b1;
                i_wb_we  = 1'b0;
                i_wb_adr = adr;
                wait_ack(name);
                data = o_wb_dat;
        endtask

        task automatic bus_idle();
                // The strobe stays up through the edge that samples ack.
                @(negedge i_clk);
                i_wb_cyc = 1'b0;
                i_wb_stb = 1'b0;
                i_wb_we  = 1'b0;
                @(negedge i_clk);
        endtask

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                checks++;
                if (actual !== expected)
                begin
                        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
                        mismatches++;
                end
        endtask

        // Ends a run whose bus accesses stop completing.
        initial
        begin
                wait (steps_ready);
                repeat (steps.size() * CYCLES_PER_STEP) @(posedge i_clk);
                $display("Watchdog expired after %0d cycles", steps.size() * CYCLES_PER_STEP);
                $display("Checks %0d, mismatches %0d, timeouts %0d",
                         checks, mismatches, timeouts + 1);
                $display("Testbench failed");
                $finish;
        end

        initial
        begin
                entry_t      e;
                logic [31:0] got;
                i_clk       = 1'b0;
                i_reset     = 1'b1;
                i_wb_cyc    = 1'b0;
                i_wb_stb    = 1'b0;
                i_wb_we     = 1'b0;
                i_wb_adr    = 5'd0;
                i_wb_dat    = 32'd0;
                checks      = 0;
                mismatches  = 0;
                timeouts    = 0;
                steps_ready = 1'b0;
                seed_ret    = $urandom(SEED);
                build_steps();
                steps_ready = 1'b1;

                repeat (2) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;
                @(negedge i_clk);
                check_value("reset_pc", 32'd0, o_pc);
                check_value("reset_ack_flush", 32'd0, {30'd0, o_wb_ack, o_flush});

                for (int n = 0; n < steps.size(); n++)
                begin
                        e = steps[n];
                        if (e.is_read)
                        begin
                                bus_read(names[n], e.adr, got);
                                check_value(names[n], e.exp, got);
                                check_value({names[n], "_pc"}, e.exp_pc, o_pc);
                                // The status word port follows the bus view.
                                if (e.adr == `ARM_ADDR_CPSR)
                                        check_value({names[n], "_cpsr"}, e.exp, o_cpsr);
                        end
                        else
                        begin
                                bus_write(names[n], e.adr, e.data);
                        end
                        // Burst writes keep stb high from one access to the next.
                        if (!e.burst)
                                bus_idle();
                end
                bus_idle();

                $display("Checks %0d, mismatches %0d, timeouts %0d",
                         checks, mismatches, timeouts);
                if (mismatches == 0 && timeouts == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/arm_state_pkg.sv
verilog/wb_state_slave.sv
verilog/state_req_fifo.sv
verilog/bank_index_map.sv
verilog/banked_register_file.sv
verilog/arm_state_top.sv
verif/tb_arm_state_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_arm_state_top \
        -f verilog.f -o tb_arm_state_top
if [ $? -ne 0 ]; then
        echo "Verilator build error"
        exit 1
fi

./obj_dir/tb_arm_state_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
        exit 1
fi
exit 0
